// ==== Makefile ====
SIM := obj_dir/bramArraySim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module bramArrayTb \
	  -f bramArray.f -o bramArraySim

# Pass only when the testbench printed its pass line
run: compile
	@out=$$(./$(SIM) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

// ==== bramArray.f ====
logic/bramArrayPkg.sv
logic/bankSelect.sv
logic/bramCell.sv
logic/readMux.sv
logic/bramArrayTop.sv
verification/bramArray_asserts.sv
verification/bramArrayTb.sv

// ==== logic/bankSelect.sv ====
`timescale 1ns/1ns

module bankSelect (
  input  bramArrayPkg::byteAddrT    addr,
  input  bramArrayPkg::arrayByteEnT wrEn,
  output bramArrayPkg::serIdxT      serIdx,
  output bramArrayPkg::wordIdxT     wordIdx,
  output bramArrayPkg::cellByteEnT
         [bramArrayPkg::numSerCells-1:0][bramArrayPkg::numParCells-1:0] cellWrEn
);

  import bramArrayPkg::*;

  logic [wordAddrBits-1:0] wordAddr;
  serIdxT                  rawRow;
  logic                    overflow;

  // Word field sits right above the byte offset
  assign wordAddr = addr[byteOffsetBits +: wordAddrBits];

  // Upper bits pick the cell row, lower bits the word inside it
  assign rawRow  = wordAddr[wordAddrBits-1 -: serIdxBits];
  assign wordIdx = wordAddr[wordIdxBits-1:0];

  // The row field can name one row more than the grid has
  assign overflow = (int'(rawRow) >= numSerCells);

  // Out of range reads fall back to row 0
  assign serIdx = overflow ? '0 : rawRow;

  // Only the addressed row sees byte enables, and only when in range
  always_comb begin
    for (int r = 0; r < numSerCells; r++) begin
      for (int p = 0; p < numParCells; p++) begin
        if (!overflow && int'(rawRow) == r) begin
          cellWrEn[r][p] = wrEn[p*cellBytes +: cellBytes];
        end else begin
          cellWrEn[r][p] = '0;
        end
      end
    end
  end

endmodule

// ==== logic/bramArrayPkg.sv ====
package bramArrayPkg;

  // Geometry of one block-RAM cell
  localparam int cellBits  = 32;
  localparam int cellBytes = cellBits / 8;
  localparam int cellWords = 256;

  // Cell grid
  // Lanes side by side form one array word, rows extend the depth
  localparam int numParCells = 2;
  localparam int numSerCells = 3;

  // Array word as seen on each port
  localparam int arrayBytes = cellBytes * numParCells;

  // Address layout, byte offset at the bottom
  localparam int byteOffsetBits = $clog2(arrayBytes);
  localparam int wordAddrBits   = $clog2(cellWords * numSerCells);
  localparam int serIdxBits     = wordAddrBits - $clog2(cellWords);
  localparam int wordIdxBits    = $clog2(cellWords);
  localparam int addrBits       = byteOffsetBits + wordAddrBits;

  // Port-level vectors
  typedef logic [addrBits-1:0]     byteAddrT;
  typedef logic [arrayBytes*8-1:0] arrayWordT;
  typedef logic [arrayBytes-1:0]   arrayByteEnT;

  // Cell-level vectors
  typedef logic [cellBits-1:0]  cellWordT;
  typedef logic [cellBytes-1:0] cellByteEnT;

  // Decoded address fields
  typedef logic [serIdxBits-1:0]  serIdxT;
  typedef logic [wordIdxBits-1:0] wordIdxT;

endpackage

// ==== logic/bramArrayTop.sv ====
`timescale 1ns/1ns

module bramArrayTop (
  input  logic                      A_PS,
  input  logic                      rstN,
  // Port a
  input  logic                      aEn,
  input  bramArrayPkg::byteAddrT    aAddr,
  input  bramArrayPkg::arrayByteEnT aWrEn,
  input  bramArrayPkg::arrayWordT   aWrData,
  output bramArrayPkg::arrayWordT   aRdData,
  // Port b
  input  logic                      bEn,
  input  bramArrayPkg::byteAddrT    bAddr,
  input  bramArrayPkg::arrayByteEnT bWrEn,
  input  bramArrayPkg::arrayWordT   bWrData,
  output bramArrayPkg::arrayWordT   bRdData
);

  import bramArrayPkg::*;

  // Decoded address of each port
  serIdxT  aSerIdx;
  serIdxT  bSerIdx;
  wordIdxT aWordIdx;
  wordIdxT bWordIdx;

  // Byte enables per cell, indexed by row then lane
  cellByteEnT [numSerCells-1:0][numParCells-1:0] aCellWrEn;
  cellByteEnT [numSerCells-1:0][numParCells-1:0] bCellWrEn;

  // Read words of every row, lanes packed side by side
  arrayWordT [numSerCells-1:0] aRowData;
  arrayWordT [numSerCells-1:0] bRowData;

  bankSelect uBankSelA (
    .addr     (aAddr),
    .wrEn     (aWrEn),
    .serIdx   (aSerIdx),
    .wordIdx  (aWordIdx),
    .cellWrEn (aCellWrEn)
  );

  bankSelect uBankSelB (
    .addr     (bAddr),
    .wrEn     (bWrEn),
    .serIdx   (bSerIdx),
    .wordIdx  (bWordIdx),
    .cellWrEn (bCellWrEn)
  );

  // Cell grid
  // Every cell of a port sees the same word index, only its own lane of data
  for (genvar s = 0; s < numSerCells; s++) begin : gRow
    for (genvar p = 0; p < numParCells; p++) begin : gLane
      bramCell uCell (
        .A_PS     (A_PS),
        .rstN     (rstN),
        .aEn      (aEn),
        .aWordIdx (aWordIdx),
        .aWrEn    (aCellWrEn[s][p]),
        .aWrData  (aWrData[p*cellBits +: cellBits]),
        .aRdData  (aRowData[s][p*cellBits +: cellBits]),
        .bEn      (bEn),
        .bWordIdx (bWordIdx),
        .bWrEn    (bCellWrEn[s][p]),
        .bWrData  (bWrData[p*cellBits +: cellBits]),
        .bRdData  (bRowData[s][p*cellBits +: cellBits])
      );
    end
  end

  readMux uReadMuxA (
    .A_PS    (A_PS),
    .rstN    (rstN),
    .en      (aEn),
    .serIdx  (aSerIdx),
    .rowData (aRowData),
    .rdData  (aRdData)
  );

  readMux uReadMuxB (
    .A_PS    (A_PS),
    .rstN    (rstN),
    .en      (bEn),
    .serIdx  (bSerIdx),
    .rowData (bRowData),
    .rdData  (bRdData)
  );

endmodule

// ==== logic/bramCell.sv ====
`timescale 1ns/1ns

module bramCell (
  input  logic                     A_PS,
  input  logic                     rstN,
  // Port a
  input  logic                     aEn,
  input  bramArrayPkg::wordIdxT    aWordIdx,
  input  bramArrayPkg::cellByteEnT aWrEn,
  input  bramArrayPkg::cellWordT   aWrData,
  output bramArrayPkg::cellWordT   aRdData,
  // Port b
  input  logic                     bEn,
  input  bramArrayPkg::wordIdxT    bWordIdx,
  input  bramArrayPkg::cellByteEnT bWrEn,
  input  bramArrayPkg::cellWordT   bWrData,
  output bramArrayPkg::cellWordT   bRdData
);

  import bramArrayPkg::*;

  cellWordT mem [cellWords];

  cellWordT aMerged;
  cellWordT bMerged;

  // Overlay the enabled bytes of new data onto the stored word
  function automatic cellWordT mergeBytes(
    input cellWordT   oldWord,
    input cellWordT   newWord,
    input cellByteEnT byteEn
  );
    cellWordT result;
    result = oldWord;
    for (int i = 0; i < cellBytes; i++) begin
      if (byteEn[i]) begin
        result[i*8 +: 8] = newWord[i*8 +: 8];
      end
    end
    return result;
  endfunction

  // Word each port will hold after its own write
  assign aMerged = mergeBytes(mem[aWordIdx], aWrData, aWrEn);
  assign bMerged = mergeBytes(mem[bWordIdx], bWrData, bWrEn);

  // Write-first on both ports
  // Outputs clear on reset, storage keeps its contents
  always_ff @(posedge A_PS) begin
    if (!rstN) begin
      aRdData <= '0;
      bRdData <= '0;
    end else begin
      if (aEn) begin
        if (|aWrEn) begin
          mem[aWordIdx] <= aMerged;
        end
        aRdData <= aMerged;
      end
      // Same-word writes from both ports in one cycle are undefined
      if (bEn) begin
        if (|bWrEn) begin
          mem[bWordIdx] <= bMerged;
        end
        bRdData <= bMerged;
      end
    end
  end

endmodule

// ==== logic/readMux.sv ====
`timescale 1ns/1ns

module readMux (
  input  logic                   A_PS,
  input  logic                   rstN,
  input  logic                   en,
  input  bramArrayPkg::serIdxT   serIdx,
  input  bramArrayPkg::arrayWordT [bramArrayPkg::numSerCells-1:0] rowData,
  output bramArrayPkg::arrayWordT rdData
);

  import bramArrayPkg::*;

  // Row of the last enabled access
  serIdxT selQ;

  // Cell outputs update one edge after the access, so the select must
  // follow them with the same delay
  always_ff @(posedge A_PS) begin
    if (!rstN) begin
      selQ <= '0;
    end else if (en) begin
      selQ <= serIdx;
    end
  end

  // Row 0 doubles as the default for any index past the grid
  always_comb begin
    rdData = rowData[0];
    for (int r = 1; r < numSerCells; r++) begin
      if (int'(selQ) == r) begin
        rdData = rowData[r];
      end
    end
  end

endmodule

// ==== verification/bramArrayTb.sv ====
`timescale 1ns/1ns

module bramArrayTb;

  import bramArrayPkg::*;

  localparam int          totalWords  = cellWords * numSerCells;
  localparam int          halfPeriod  = 20;
  localparam int          resetCycles = 4;
  localparam int          resetLimit  = 16;
  localparam int          phaseLimit  = 2000;
  localparam int          runLimitNs  = 200000;
  localparam logic [15:0] lfsrSeed    = 16'd58707;

  logic        A_PS;
  logic        rstN;
  logic        aEn;
  byteAddrT    aAddr;
  arrayByteEnT aWrEn;
  arrayWordT   aWrData;
  arrayWordT   aRdData;
  logic        bEn;
  byteAddrT    bAddr;
  arrayByteEnT bWrEn;
  arrayWordT   bWrData;
  arrayWordT   bRdData;

  // Expected read words, published one edge after each access
  arrayWordT   aExp;
  arrayWordT   bExp;
  logic        checkEn;
  int          cycleCount;
  logic [15:0] lfsrState;
  arrayWordT   shadow [totalWords];

  bramArrayTop u_dut (
    .A_PS    (A_PS),
    .rstN    (rstN),
    .aEn     (aEn),
    .aAddr   (aAddr),
    .aWrEn   (aWrEn),
    .aWrData (aWrData),
    .aRdData (aRdData),
    .bEn     (bEn),
    .bAddr   (bAddr),
    .bWrEn   (bWrEn),
    .bWrData (bWrData),
    .bRdData (bRdData)
  );

  bind bramArrayTop bramArrayAsserts uAsserts (
    .A_PS    (A_PS),
    .rstN    (rstN),
    .aEn     (aEn),
    .bEn     (bEn),
    .aRdData (aRdData),
    .bRdData (bRdData),
    .aExp    (bramArrayTb.aExp),
    .bExp    (bramArrayTb.bExp),
    .checkEn (bramArrayTb.checkEn)
  );

  always #halfPeriod A_PS = ~A_PS;

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsrState[0];
      lfsrState = lfsrNext(lfsrState);
    end
    return v;
  endfunction

  function automatic arrayWordT randWord();
    return randBits(64);
  endfunction

  function automatic wordIdxT randIdx();
    logic [63:0] r;
    r = randBits(wordIdxBits);
    return r[wordIdxBits-1:0];
  endfunction

  function automatic arrayByteEnT randMask();
    logic [63:0] r;
    r = randBits(arrayBytes);
    return r[arrayBytes-1:0];
  endfunction

  function automatic int randRow();
    logic [63:0] r;
    r = randBits(2);
    return int'(r[1:0]) % numSerCells;
  endfunction

  // Random byte offset below the word field, which the array ignores
  function automatic byteAddrT makeAddr(input int wordAddr);
    logic [63:0] off;
    logic [31:0] wa;
    off = randBits(byteOffsetBits);
    wa = wordAddr;
    return {wa[wordAddrBits-1:0], off[byteOffsetBits-1:0]};
  endfunction

  // Shadow model of one port access, returns the word the port reads back
  function automatic arrayWordT applyAccess(
    input byteAddrT    addr,
    input arrayByteEnT we,
    input arrayWordT   data
  );
    logic [wordAddrBits-1:0] wa;
    int                      idx;
    arrayWordT               word;
    wa = addr[byteOffsetBits +: wordAddrBits];
    idx = int'(wa);
    // Past the last row nothing is written and row 0 answers
    if (idx >= totalWords) begin
      return shadow[idx % cellWords];
    end
    word = shadow[idx];
    for (int i = 0; i < arrayBytes; i++) begin
      if (we[i]) begin
        word[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    shadow[idx] = word;
    return word;
  endfunction

  always @(posedge A_PS) begin
    cycleCount <= cycleCount + 1;
    if (!rstN) begin
      aExp    <= '0;
      bExp    <= '0;
      checkEn <= 1'b1;
    end else begin
      if (aEn) begin
        aExp <= applyAccess(aAddr, aWrEn, aWrData);
      end
      if (bEn) begin
        bExp <= applyAccess(bAddr, bWrEn, bWrData);
      end
    end
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  always @(negedge A_PS) begin
    if (u_dut.uAsserts.failCount != 0) begin
      failRun("a read data assertion failed");
    end
  end

  initial begin
    #(runLimitNs);
    failRun("timeout: the run did not finish in time");
  end

  // One access on the chosen port, the other port idle
  task automatic op(input bit onB, input byteAddrT addr, input arrayByteEnT we,
                    input arrayWordT data);
    @(posedge A_PS);
    aEn     <= !onB;
    aAddr   <= addr;
    aWrEn   <= onB ? '0 : we;
    aWrData <= data;
    bEn     <= onB;
    bAddr   <= addr;
    bWrEn   <= onB ? we : '0;
    bWrData <= data;
  endtask

  task automatic idle();
    @(posedge A_PS);
    aEn   <= 1'b0;
    aWrEn <= '0;
    bEn   <= 1'b0;
    bWrEn <= '0;
  endtask

  task automatic checkBudget(input string phase, input int startCycle);
    if (cycleCount - startCycle > phaseLimit) begin
      failRun($sformatf("timeout: phase %s took over %0d cycles", phase, phaseLimit));
    end
  endtask

  task automatic waitReadZero();
    int waited;
    waited = 0;
    while (aRdData !== '0 || bRdData !== '0) begin
      if (waited >= resetLimit) begin
        failRun("read data did not clear while reset was held");
      end
      @(posedge A_PS);
      waited++;
    end
  endtask

  initial begin
    int       start;
    byteAddrT addr;
    wordIdxT  idx;
    A_PS = 1'b0;
    rstN = 1'b0;
    aEn = 1'b0;
    aAddr = '0;
    aWrEn = '0;
    aWrData = '0;
    bEn = 1'b0;
    bAddr = '0;
    bWrEn = '0;
    bWrData = '0;
    checkEn = 1'b0;
    cycleCount = 0;
    lfsrState = lfsrSeed;

    for (int i = 0; i < resetCycles; i++) begin
      @(posedge A_PS);
    end
    waitReadZero();
    rstN <= 1'b1;
    idle();

    // Every word gets a defined value before any read
    start = cycleCount;
    for (int wa = 0; wa < totalWords; wa++) begin
      op(1'b0, makeAddr(wa), '1, randWord());
    end
    checkBudget("fill", start);

    // Full words written on a, read back on b, in every row
    start = cycleCount;
    for (int row = 0; row < numSerCells; row++) begin
      for (int k = 0; k < 8; k++) begin
        addr = makeAddr(row * cellWords + int'(randIdx()));
        op(1'b0, addr, '1, randWord());
        op(1'b1, addr, '0, '0);
      end
    end
    checkBudget("row writes", start);

    // Partial byte masks on b, read back on a
    start = cycleCount;
    for (int k = 0; k < 12; k++) begin
      addr = makeAddr(randRow() * cellWords + int'(randIdx()));
      op(1'b1, addr, randMask(), randWord());
      op(1'b0, addr, '0, '0);
    end
    checkBudget("partial writes", start);

    // Serial index 3 drops the write and reads row 0
    start = cycleCount;
    for (int k = 0; k < 6; k++) begin
      idx = randIdx();
      op(1'b0, makeAddr(totalWords + int'(idx)), '1, randWord());
      op(1'b1, makeAddr(totalWords + int'(idx)), '0, '0);
      for (int row = 0; row < numSerCells; row++) begin
        op(1'b1, makeAddr(row * cellWords + int'(idx)), '0, '0);
      end
    end
    checkBudget("out of range", start);

    // Port a holds its word while b rewrites it
    start = cycleCount;
    for (int k = 0; k < 6; k++) begin
      addr = makeAddr(randRow() * cellWords + int'(randIdx()));
      op(1'b0, addr, '0, '0);
      op(1'b1, addr, '1, randWord());
      idle();
      op(1'b0, addr, '0, '0);
    end
    checkBudget("hold", start);

    // Let the last access reach its check
    for (int i = 0; i < 3; i++) begin
      idle();
    end

    if (u_dut.uAsserts.failCount != 0) begin
      failRun("read data assertions failed during the run");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== verification/bramArray_asserts.sv ====
`timescale 1ns/1ns

module bramArrayAsserts (
  input logic                    A_PS,
  input logic                    rstN,
  input logic                    aEn,
  input logic                    bEn,
  input bramArrayPkg::arrayWordT aRdData,
  input bramArrayPkg::arrayWordT bRdData,
  input bramArrayPkg::arrayWordT aExp,
  input bramArrayPkg::arrayWordT bExp,
  input logic                    checkEn
);

  int failCount = 0;

  // Read data follows the shadow model one cycle after each access
  aReadMatch: assert property (@(posedge A_PS) checkEn |-> aRdData == aExp)
    else begin
      $error("mismatch at %0t: aRdData is %h, expected %h",
             $time, $sampled(aRdData), $sampled(aExp));
      failCount = failCount + 1;
    end

  bReadMatch: assert property (@(posedge A_PS) checkEn |-> bRdData == bExp)
    else begin
      $error("mismatch at %0t: bRdData is %h, expected %h",
             $time, $sampled(bRdData), $sampled(bExp));
      failCount = failCount + 1;
    end

  // A reset edge clears both output registers
  resetClears: assert property (@(posedge A_PS) !rstN |=> (aRdData == '0 && bRdData == '0))
    else begin
      $error("read data not cleared one cycle after a reset edge");
      failCount = failCount + 1;
    end

  // An idle port keeps the word of its last access
  aHold: assert property (@(posedge A_PS) disable iff (!rstN) !aEn |=> $stable(aRdData))
    else begin
      $error("aRdData changed while port a was idle");
      failCount = failCount + 1;
    end

  bHold: assert property (@(posedge A_PS) disable iff (!rstN) !bEn |=> $stable(bRdData))
    else begin
      $error("bRdData changed while port b was idle");
      failCount = failCount + 1;
    end

endmodule
